// File: common/mb_regs_defs.svh
// register map constants for the motherboard register subsystem
// base addresses, sizes, offsets, status codes, timeout, signature

`ifndef MB_REGS_DEFS_SVH
`define MB_REGS_DEFS_SVH

// --------------------------------------------------
// ctrlport response status codes
// --------------------------------------------------
`define CTRL_STS_OKAY           2'd0
`define CTRL_STS_CMDERR         2'd1

// --------------------------------------------------
// general block
// --------------------------------------------------
`define GENERAL_REG_BASE        20'h00000
`define GENERAL_REG_SIZE        20'h20

// offsets from the general block base
`define SIGNATURE_OFFS          20'h0
`define SCRATCH_OFFS            20'h4
`define WRITE_COUNT_OFFS        20'h8

// reads back as ascii "MBRG"
`define MB_SIGNATURE            32'h4D425247

// --------------------------------------------------
// versioning block
// --------------------------------------------------
// 1 KiB aligned, component index sits in addr[9:4]
`define VERSIONING_REG_BASE     20'h00400
`define MAX_NUM_OF_COMPONENTS   64
// four 32-bit words per component
`define VERSIONING_REG_SIZE     (`MAX_NUM_OF_COMPONENTS * 16)

// offsets within one 16-byte component slot
`define CURRENT_VERSION_OFFS    4'h0
`define OLDEST_COMPATIBLE_OFFS  4'h4
`define LAST_MODIFIED_OFFS      4'h8
`define RESERVED_OFFS           4'hC

// cycles the splitter waits for a slave before erroring out
`define SPLITTER_TIMEOUT        16

`endif

// File: common/mb_regs_pkg.sv
// shared types for the motherboard register subsystem
// ctrlport request/response structs, version structs, splitter states

`include "mb_regs_defs.svh"

package mb_regs_pkg;

  // --------------------------------------------------
  // ctrlport field widths
  // --------------------------------------------------
  typedef logic [19:0] ctrl_addr_t;
  typedef logic [31:0] ctrl_data_t;
  typedef logic [1:0]  ctrl_status_t;

  // --------------------------------------------------
  // versioning
  // --------------------------------------------------
  // major/minor/build packed into one word
  typedef logic [31:0] version_t;
  // hex YYMMDDHH
  typedef logic [31:0] timestamp_t;

  // one component, current version in the low word
  typedef struct packed {
    timestamp_t last_modified;
    version_t   oldest_compatible;
    version_t   current;
  } component_versions_t;

  // all components, index 0 in the lowest 96 bits
  typedef component_versions_t [`MAX_NUM_OF_COMPONENTS-1:0] version_info_t;

  // --------------------------------------------------
  // ctrlport bus
  // --------------------------------------------------
  // one-cycle request, wr and rd never both high
  typedef struct packed {
    logic       wr;
    logic       rd;
    ctrl_addr_t addr;
    ctrl_data_t data;
  } ctrlport_req_t;

  // data only meaningful while ack is high
  typedef struct packed {
    logic         ack;
    ctrl_status_t status;
    ctrl_data_t   data;
  } ctrlport_resp_t;

  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_timeout
  } splitter_state_t;

endpackage

// File: versioning/versioning_regs.sv
// read-only versioning registers, four words per component
// current, oldest compatible, last modified and a reserved slot

`timescale 1ns/10ps

`include "mb_regs_defs.svh"

`default_nettype none

module versioning_regs
  import mb_regs_pkg::*;
(
  input  wire logic       s_ctrlport_clk,
  input  wire logic       s_ctrlport_rst,
  // slave side of ctrlport
  input  ctrlport_req_t   s_req,
  output ctrlport_resp_t  s_resp,
  // quasi-static, reported by each component
  input  version_info_t   version_info
);

  // first address past the block
  localparam ctrl_addr_t REG_END =
    ctrl_addr_t'(`VERSIONING_REG_BASE + `VERSIONING_REG_SIZE);
  // 64 components -> 6 index bits
  localparam int IDX_W = $clog2(`MAX_NUM_OF_COMPONENTS);

  logic                address_in_range;
  logic                req_valid;
  logic [IDX_W-1:0]    component_index;
  logic [3:0]          reg_offs;
  component_versions_t component_versions;

  // --------------------------------------------------
  // address decode
  // --------------------------------------------------
  assign req_valid = s_req.wr | s_req.rd;

  assign address_in_range = (s_req.addr >= `VERSIONING_REG_BASE) &&
                            (s_req.addr < REG_END);

  // addr[9:4] picks the component, addr[3:0] the word in its slot
  assign component_index = s_req.addr[4 +: IDX_W];
  assign reg_offs        = s_req.addr[3:0];

  // select the addressed component's 96 bits
  assign component_versions = version_info[component_index];

  // --------------------------------------------------
  // response
  // --------------------------------------------------
  always_ff @(posedge s_ctrlport_clk) begin
    if (s_ctrlport_rst) begin
      s_resp.ack    <= 1'b0;
      s_resp.status <= `CTRL_STS_OKAY;
    end else begin
      // single-cycle ack
      s_resp.ack <= 1'b0;

      // silent outside our range, the splitter owns that case
      if (req_valid && address_in_range) begin
        s_resp.ack    <= 1'b1;
        s_resp.status <= `CTRL_STS_OKAY;
        s_resp.data   <= '0;

        if (s_req.wr) begin
          // nothing writable here
          s_resp.status <= `CTRL_STS_CMDERR;
        end else begin
          case (reg_offs)
            `CURRENT_VERSION_OFFS: begin
              s_resp.data <= component_versions.current;
            end
            `OLDEST_COMPATIBLE_OFFS: begin
              s_resp.data <= component_versions.oldest_compatible;
            end
            `LAST_MODIFIED_OFFS: begin
              s_resp.data <= component_versions.last_modified;
            end
            // slot kept free for a later field
            `RESERVED_OFFS: begin
              s_resp.status <= `CTRL_STS_CMDERR;
            end
            // unaligned word offsets
            default: begin
              s_resp.status <= `CTRL_STS_CMDERR;
            end
          endcase
        end
      end
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  // one request in flight at a time, so acks are isolated pulses
  ack_single_cycle_a : assert property (
    @(posedge s_ctrlport_clk) disable iff (s_ctrlport_rst)
    s_resp.ack |=> !s_resp.ack
  ) else $error("versioning_regs: ack held for two cycles");

endmodule

`default_nettype wire

// File: verilog/general_regs.sv
// general registers: signature, scratch and write count
// ctrlport slave, ack one cycle after an in-range request

`timescale 1ns/10ps

`include "mb_regs_defs.svh"

`default_nettype none

module general_regs
  import mb_regs_pkg::*;
(
  input  wire logic      s_ctrlport_clk,
  input  wire logic      s_ctrlport_rst,
  input  ctrlport_req_t  s_req,
  output ctrlport_resp_t s_resp
);

  localparam ctrl_addr_t REG_END = ctrl_addr_t'(`GENERAL_REG_BASE + `GENERAL_REG_SIZE);

  logic       address_in_range;
  logic       req_in_range;
  ctrl_addr_t reg_offs;
  ctrl_data_t scratch;
  ctrl_data_t write_count;

  // --------------------------------------------------
  // decode
  // --------------------------------------------------
  assign address_in_range = (s_req.addr >= `GENERAL_REG_BASE) && (s_req.addr < REG_END);
  assign req_in_range     = (s_req.wr | s_req.rd) & address_in_range;
  assign reg_offs         = s_req.addr - `GENERAL_REG_BASE;

  // --------------------------------------------------
  // registers and response
  // --------------------------------------------------
  always_ff @(posedge s_ctrlport_clk) begin
    if (s_ctrlport_rst) begin
      s_resp.ack    <= 1'b0;
      s_resp.status <= `CTRL_STS_OKAY;
      scratch       <= '0;
      write_count   <= '0;
    end else begin
      s_resp.ack <= 1'b0;

      if (req_in_range) begin
        s_resp.ack    <= 1'b1;
        s_resp.status <= `CTRL_STS_OKAY;
        s_resp.data   <= '0;

        if (s_req.wr) begin
          case (reg_offs)
            `SCRATCH_OFFS: begin
              scratch     <= s_req.data;
              // only accepted writes count, wraps at 32 bits
              write_count <= write_count + 1'b1;
            end
            // read-only, not counted
            `SIGNATURE_OFFS, `WRITE_COUNT_OFFS: begin
              s_resp.status <= `CTRL_STS_CMDERR;
            end
            default: begin
              s_resp.status <= `CTRL_STS_CMDERR;
            end
          endcase
        end else begin
          case (reg_offs)
            `SIGNATURE_OFFS:   s_resp.data <= `MB_SIGNATURE;
            `SCRATCH_OFFS:     s_resp.data <= scratch;
            `WRITE_COUNT_OFFS: s_resp.data <= write_count;
            // undefined offset inside our range
            default:           s_resp.status <= `CTRL_STS_CMDERR;
          endcase
        end
      end
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  // in-range request answered on the very next cycle, and for that cycle only
  ack_latency_a : assert property (
    @(posedge s_ctrlport_clk) disable iff (s_ctrlport_rst)
    req_in_range |=> s_resp.ack ##1 !s_resp.ack
  ) else $error("general_regs: ack not a single pulse one cycle after request");

endmodule

`default_nettype wire

// File: verilog/ctrlport_splitter.sv
// ctrlport splitter: broadcast request to all slaves, merge responses
// error ack after a fixed timeout when no slave claims the address

`timescale 1ns/10ps

`include "mb_regs_defs.svh"

`default_nettype none

module ctrlport_splitter
  import mb_regs_pkg::*;
#(
  parameter int NUM_SLAVES = 2
) (
  input  wire logic                       s_ctrlport_clk,
  input  wire logic                       s_ctrlport_rst,
  // from the bus master
  input  ctrlport_req_t                   s_req,
  output ctrlport_resp_t                  s_resp,
  // to the register blocks
  output ctrlport_req_t                   m_req,
  input  ctrlport_resp_t [NUM_SLAVES-1:0] m_resp
);

  // counter covers 0 .. timeout-1
  localparam int               CNT_W    = $clog2(`SPLITTER_TIMEOUT + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SPLITTER_TIMEOUT - 1);

  splitter_state_t       state;
  logic [CNT_W-1:0]      wait_cnt;
  logic [NUM_SLAVES-1:0] slave_ack;
  logic                  req_valid;
  ctrlport_resp_t        merged_resp;

  assign req_valid = s_req.wr | s_req.rd;

  // --------------------------------------------------
  // response merge
  // --------------------------------------------------
  // walk down so the lowest acking index wins
  always_comb begin
    merged_resp = '0;
    for (int i = NUM_SLAVES - 1; i >= 0; i--) begin
      slave_ack[i] = m_resp[i].ack;
      if (m_resp[i].ack) begin
        merged_resp = m_resp[i];
      end
    end
  end

  // --------------------------------------------------
  // transaction FSM
  // --------------------------------------------------
  always_ff @(posedge s_ctrlport_clk) begin
    if (s_ctrlport_rst) begin
      state         <= st_idle;
      wait_cnt      <= '0;
      m_req.wr      <= 1'b0;
      m_req.rd      <= 1'b0;
      s_resp.ack    <= 1'b0;
      s_resp.status <= `CTRL_STS_OKAY;
    end else begin
      // strobes are one-cycle pulses
      m_req.wr   <= 1'b0;
      m_req.rd   <= 1'b0;
      s_resp.ack <= 1'b0;

      case (state)
        st_idle: begin
          if (req_valid) begin
            m_req    <= s_req;
            wait_cnt <= '0;
            state    <= st_wait;
          end
        end
        st_wait: begin
          // slaves answer one cycle after m_req
          if (merged_resp.ack) begin
            s_resp <= merged_resp;
            state  <= st_idle;
          end else if (wait_cnt == CNT_LAST) begin
            state <= st_timeout;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        st_timeout: begin
          // nobody owns the address
          s_resp.ack    <= 1'b1;
          s_resp.status <= `CTRL_STS_CMDERR;
          s_resp.data   <= '0;
          state         <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  // overlapping address ranges in the slaves
  one_slave_ack_a : assert property (
    @(posedge s_ctrlport_clk) disable iff (s_ctrlport_rst)
    $onehot0(slave_ack)
  ) else $error("ctrlport_splitter: more than one slave acked");

  // master must wait for ack, ctrlport has no back-pressure
  req_when_idle_a : assert property (
    @(posedge s_ctrlport_clk) disable iff (s_ctrlport_rst)
    req_valid |-> (state == st_idle)
  ) else $error("ctrlport_splitter: request while busy");

endmodule

`default_nettype wire

// File: verilog/mb_regs_top.sv
// motherboard register subsystem top level
// splitter in front of the versioning and general register blocks

`timescale 1ns/10ps

`default_nettype none

module mb_regs_top
  import mb_regs_pkg::*;
(
  input  wire logic     s_ctrlport_clk,
  input  wire logic     s_ctrlport_rst,
  // ctrlport from the master
  input  ctrlport_req_t  req,
  output ctrlport_resp_t resp,
  // version vectors of all components
  input  version_info_t  version_info
);

  // slot 0 versioning, slot 1 general
  localparam int NUM_SLAVES = 2;

  ctrlport_req_t                   slave_req;
  ctrlport_resp_t [NUM_SLAVES-1:0] slave_resp;

  // --------------------------------------------------
  // request fan-out and response merge
  // --------------------------------------------------
  ctrlport_splitter #(
    .NUM_SLAVES (NUM_SLAVES)
  ) splitter_i (
    .s_ctrlport_clk (s_ctrlport_clk),
    .s_ctrlport_rst (s_ctrlport_rst),
    .s_req          (req),
    .s_resp         (resp),
    .m_req          (slave_req),
    .m_resp         (slave_resp)
  );

  // --------------------------------------------------
  // register blocks
  // --------------------------------------------------
  versioning_regs versioning_regs_i (
    .s_ctrlport_clk (s_ctrlport_clk),
    .s_ctrlport_rst (s_ctrlport_rst),
    .s_req          (slave_req),
    .s_resp         (slave_resp[0]),
    .version_info   (version_info)
  );

  general_regs general_regs_i (
    .s_ctrlport_clk (s_ctrlport_clk),
    .s_ctrlport_rst (s_ctrlport_rst),
    .s_req          (slave_req),
    .s_resp         (slave_resp[1])
  );

endmodule

`default_nettype wire

// File: tb/mb_regs_tb.sv
// testbench for the motherboard register subsystem
// bus tasks, reference model of the registers, concurrent checks

`timescale 1ns/10ps

`include "mb_regs_defs.svh"

module mb_regs_tb
  import mb_regs_pkg::*;
();

  // 150 transactions at the unmapped latency, rounded up
  localparam int MAX_CYCLES   = 4000;
  // cycles without ack before an unmapped request is answered
  localparam int UNMAPPED_GAP = `SPLITTER_TIMEOUT + 1;

  logic                                 s_ctrlport_clk = 1'b0;
  logic                                 s_ctrlport_rst;
  ctrlport_req_t                        req;
  ctrlport_resp_t                       resp;
  logic [`MAX_NUM_OF_COMPONENTS*96-1:0] version_flat;
  logic                                 req_valid;

  // reference model
  ctrl_data_t   cur_ver  [`MAX_NUM_OF_COMPONENTS];
  ctrl_data_t   old_ver  [`MAX_NUM_OF_COMPONENTS];
  ctrl_data_t   mod_time [`MAX_NUM_OF_COMPONENTS];
  ctrl_data_t   scratch_model;
  ctrl_data_t   write_count_model;

  // expected response of the request in flight
  ctrl_status_t exp_status;
  ctrl_data_t   exp_data;
  logic         exp_mapped;

  int cycle_count = 0;
  int error_count = 0;
  int txn_count   = 0;
  int test_count  = 0;
  int test_err_start;
  int test_txn_start;

  mb_regs_top dut_i (
    .s_ctrlport_clk (s_ctrlport_clk),
    .s_ctrlport_rst (s_ctrlport_rst),
    .req            (req),
    .resp           (resp),
    .version_info   (version_flat)
  );

  // 4 ns period
  always #2 s_ctrlport_clk = ~s_ctrlport_clk;

  assign req_valid = req.wr | req.rd;

  // --------------------------------------------------
  // watchdog
  // --------------------------------------------------
  always @(posedge s_ctrlport_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == MAX_CYCLES) begin
      $display("run hung: no end after %0d cycles at %0t", MAX_CYCLES, $time);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  // mapped: request, two quiet cycles, then ack
  mapped_latency_a : assert property (
    @(posedge s_ctrlport_clk) disable iff (s_ctrlport_rst)
    (req_valid && exp_mapped) |=> !resp.ack ##1 !resp.ack ##1 resp.ack
  ) else begin
    $display("ERROR %0t: mapped request not acked exactly 3 cycles later", $time);
    error_count++;
  end

  // unmapped: splitter waits out its timeout
  unmapped_latency_a : assert property (
    @(posedge s_ctrlport_clk) disable iff (s_ctrlport_rst)
    (req_valid && !exp_mapped) |=> (!resp.ack)[*UNMAPPED_GAP] ##1 resp.ack
  ) else begin
    $display("ERROR %0t: unmapped request not acked after the timeout", $time);
    error_count++;
  end

  resp_value_a : assert property (
    @(posedge s_ctrlport_clk) disable iff (s_ctrlport_rst)
    resp.ack |-> (resp.status == exp_status) && (resp.data == exp_data)
  ) else begin
    $display("ERROR %0t: got status %0d data %h, expected status %0d data %h",
             $time, $sampled(resp.status), $sampled(resp.data),
             $sampled(exp_status), $sampled(exp_data));
    error_count++;
  end

  // first edge skipped, outputs still unknown there
  ack_low_in_reset_a : assert property (
    @(posedge s_ctrlport_clk)
    (s_ctrlport_rst && cycle_count != 0) |-> !resp.ack
  ) else begin
    $display("ERROR %0t: ack high during reset", $time);
    error_count++;
  end

  ack_low_after_reset_a : assert property (
    @(posedge s_ctrlport_clk) $fell(s_ctrlport_rst) |-> !resp.ack
  ) else begin
    $display("ERROR %0t: ack high right after reset", $time);
    error_count++;
  end

  // --------------------------------------------------
  // bus tasks
  // --------------------------------------------------
  // called on a rising edge, returns on the edge that sees ack
  task automatic run_request(input logic wr, input ctrl_addr_t addr,
                             input ctrl_data_t wdata, input ctrl_status_t status,
                             input ctrl_data_t rdata, input logic mapped);
    req.wr     <= wr;
    req.rd     <= ~wr;
    req.addr   <= addr;
    req.data   <= wdata;
    exp_status <= status;
    exp_data   <= rdata;
    exp_mapped <= mapped;
    @(posedge s_ctrlport_clk);
    req.wr <= 1'b0;
    req.rd <= 1'b0;
    @(posedge s_ctrlport_clk);
    while (!resp.ack) begin
      @(posedge s_ctrlport_clk);
    end
    txn_count++;
  endtask

  task automatic read_reg(input ctrl_addr_t addr, input ctrl_status_t status,
                          input ctrl_data_t rdata, input logic mapped);
    run_request(1'b0, addr, '0, status, rdata, mapped);
  endtask

  // write responses carry data 0
  task automatic write_reg(input ctrl_addr_t addr, input ctrl_data_t wdata,
                           input ctrl_status_t status, input logic mapped);
    run_request(1'b1, addr, wdata, status, '0, mapped);
  endtask

  task automatic start_test();
    test_err_start = error_count;
    test_txn_start = txn_count;
  endtask

  task automatic finish_test(input string name);
    // action blocks of the last ack run on that edge
    @(posedge s_ctrlport_clk);
    test_count++;
    $display("test %s: %0d transactions, %0d errors", name,
             txn_count - test_txn_start, error_count - test_err_start);
  endtask

  // random versions, component i in bits i*96 and up, current lowest
  task automatic fill_versions();
    for (int i = 0; i < `MAX_NUM_OF_COMPONENTS; i++) begin
      cur_ver[i]  = $urandom;
      old_ver[i]  = $urandom;
      mod_time[i] = $urandom;
      version_flat[i*96 +: 32]      = cur_ver[i];
      version_flat[i*96 + 32 +: 32] = old_ver[i];
      version_flat[i*96 + 64 +: 32] = mod_time[i];
    end
  endtask

  // --------------------------------------------------
  // tests
  // --------------------------------------------------
  task automatic check_reset_state();
    start_test();
    read_reg(`GENERAL_REG_BASE + `SCRATCH_OFFS, `CTRL_STS_OKAY, '0, 1'b1);
    read_reg(`GENERAL_REG_BASE + `WRITE_COUNT_OFFS, `CTRL_STS_OKAY, '0, 1'b1);
    finish_test("reset state");
  endtask

  task automatic check_version_reads();
    int         idx;
    ctrl_addr_t base;
    start_test();
    for (int n = 0; n < 40; n++) begin
      idx  = $urandom_range(`MAX_NUM_OF_COMPONENTS - 1, 0);
      base = `VERSIONING_REG_BASE + ctrl_addr_t'(idx * 16);
      read_reg(base + `CURRENT_VERSION_OFFS, `CTRL_STS_OKAY, cur_ver[idx], 1'b1);
      read_reg(base + `OLDEST_COMPATIBLE_OFFS, `CTRL_STS_OKAY, old_ver[idx], 1'b1);
      read_reg(base + `LAST_MODIFIED_OFFS, `CTRL_STS_OKAY, mod_time[idx], 1'b1);
    end
    finish_test("versioning reads");
  endtask

  task automatic check_version_errors();
    int         idx;
    ctrl_addr_t base;
    start_test();
    for (int n = 0; n < 6; n++) begin
      idx  = $urandom_range(`MAX_NUM_OF_COMPONENTS - 1, 0);
      base = `VERSIONING_REG_BASE + ctrl_addr_t'(idx * 16);
      read_reg(base + `RESERVED_OFFS, `CTRL_STS_CMDERR, '0, 1'b1);
      // unaligned word
      read_reg(base + 20'h2, `CTRL_STS_CMDERR, '0, 1'b1);
      // whole block is read-only
      for (int offs = 0; offs < 16; offs += 4) begin
        write_reg(base + ctrl_addr_t'(offs), $urandom, `CTRL_STS_CMDERR, 1'b1);
      end
    end
    finish_test("versioning errors");
  endtask

  task automatic check_scratch();
    ctrl_data_t wdata;
    start_test();
    for (int n = 0; n < 20; n++) begin
      wdata = $urandom;
      write_reg(`GENERAL_REG_BASE + `SCRATCH_OFFS, wdata, `CTRL_STS_OKAY, 1'b1);
      scratch_model     = wdata;
      write_count_model = write_count_model + 1;
      read_reg(`GENERAL_REG_BASE + `SCRATCH_OFFS, `CTRL_STS_OKAY, scratch_model, 1'b1);
      read_reg(`GENERAL_REG_BASE + `SIGNATURE_OFFS, `CTRL_STS_OKAY, `MB_SIGNATURE, 1'b1);
    end
    finish_test("scratch read-back");
  endtask

  task automatic check_write_count();
    ctrl_data_t wdata;
    start_test();
    for (int n = 0; n < 5; n++) begin
      wdata = $urandom;
      write_reg(`GENERAL_REG_BASE + `SCRATCH_OFFS, wdata, `CTRL_STS_OKAY, 1'b1);
      scratch_model     = wdata;
      write_count_model = write_count_model + 1;
    end
    read_reg(`GENERAL_REG_BASE + `WRITE_COUNT_OFFS, `CTRL_STS_OKAY, write_count_model, 1'b1);
    // rejected writes leave the count alone
    write_reg(`GENERAL_REG_BASE + `SIGNATURE_OFFS, $urandom, `CTRL_STS_CMDERR, 1'b1);
    write_reg(`GENERAL_REG_BASE + `WRITE_COUNT_OFFS, $urandom, `CTRL_STS_CMDERR, 1'b1);
    write_reg(`GENERAL_REG_BASE + 20'h1C, $urandom, `CTRL_STS_CMDERR, 1'b1);
    read_reg(`GENERAL_REG_BASE + 20'hC, `CTRL_STS_CMDERR, '0, 1'b1);
    read_reg(`GENERAL_REG_BASE + `WRITE_COUNT_OFFS, `CTRL_STS_OKAY, write_count_model, 1'b1);
    read_reg(`GENERAL_REG_BASE + `SCRATCH_OFFS, `CTRL_STS_OKAY, scratch_model, 1'b1);
    finish_test("write count");
  endtask

  // gaps below, between and above the two blocks
  task automatic check_unmapped();
    start_test();
    read_reg(20'h00020, `CTRL_STS_CMDERR, '0, 1'b0);
    write_reg(20'h00100, $urandom, `CTRL_STS_CMDERR, 1'b0);
    read_reg(20'h00800, `CTRL_STS_CMDERR, '0, 1'b0);
    read_reg(20'hFFFFC, `CTRL_STS_CMDERR, '0, 1'b0);
    finish_test("unmapped addresses");
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    void'($urandom(32'h529d));
    s_ctrlport_rst    = 1'b1;
    req               = '0;
    exp_status        = `CTRL_STS_OKAY;
    exp_data          = '0;
    exp_mapped        = 1'b1;
    scratch_model     = '0;
    write_count_model = '0;
    fill_versions();

    repeat (4) @(posedge s_ctrlport_clk);
    s_ctrlport_rst <= 1'b0;

    check_reset_state();
    check_version_reads();
    check_version_errors();
    check_scratch();
    check_write_count();
    check_unmapped();

    @(posedge s_ctrlport_clk);
    $display("tests %0d, transactions %0d, errors %0d", test_count, txn_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+common
common/mb_regs_pkg.sv
versioning/versioning_regs.sv
verilog/general_regs.sv
verilog/ctrlport_splitter.sv
verilog/mb_regs_top.sv
tb/mb_regs_tb.sv
